/* build.f */
+incdir+rtl
rtl/fft_sample_pkg.sv
rtl/fft_ctrl_pkg.sv
rtl/delay_line.sv
rtl/radix3_butterfly.sv
rtl/sdf_stage.sv
rtl/twiddle_rotator.sv
rtl/fft9_top.sv
tests/fft9_tb.sv

/* rtl/delay_line.sv */
module delay_line #(
    parameter int DEPTH = 1  // latency in cycles
) (
    input  logic                    clk,
    input  fft_sample_pkg::sample_t in_data,
    output fft_sample_pkg::sample_t out_data
);

    fft_sample_pkg::sample_t taps [DEPTH];  // taps[0] newest

    // free running shift, no enable
    always_ff @(posedge clk) begin
        taps[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            taps[i] <= taps[i-1];  // move one slot on
        end
    end

    assign out_data = taps[DEPTH-1];  // entered DEPTH cycles ago

endmodule

/* rtl/fft9_top.sv */
module fft9_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    di_en,
    input  fft_sample_pkg::sample_t di,
    output logic                    do_en,
    output fft_sample_pkg::sample_t do_data
);

    logic                    s1_valid;  // stage 1 out
    fft_sample_pkg::sample_t s1_data;
    logic                    tw_valid;  // after twiddle
    fft_sample_pkg::sample_t tw_data;

    // ------------------------------------------------------------
    // span 3 stage, then rotate, then span 1 stage
    // ------------------------------------------------------------
    sdf_stage #(.SPAN(3)) stage1_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (di_en),
        .in_data   (di),
        .out_valid (s1_valid),
        .out_data  (s1_data)
    );

    twiddle_rotator rotator_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s1_valid),
        .in_data   (s1_data),
        .out_valid (tw_valid),
        .out_data  (tw_data)
    );

    sdf_stage #(.SPAN(1)) stage2_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (tw_valid),
        .in_data   (tw_data),
        .out_valid (do_en),     // digit-reversed bins
        .out_data  (do_data)
    );

endmodule

/* rtl/fft_ctrl_pkg.sv */
`include "fft_defines.svh"

package fft_ctrl_pkg;

    // ------------------------------------------------------------
    // sample position bookkeeping
    // ------------------------------------------------------------
    typedef logic [$clog2(`FFT_POINTS)-1:0] frame_pos_t;  // 0 .. points-1

    // one base-3 digit of a position, 0 .. 2
    typedef logic [$clog2(`FFT_RADIX)-1:0] digit_t;

endpackage

/* rtl/fft_defines.svh */
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define FFT_DATA_W 16         // re and im part width
`define FFT_COEF_W 16         // signed q1.15 coefficients

// ------------------------------------------------------------
// transform shape
// ------------------------------------------------------------
`define FFT_POINTS 9          // samples per frame
`define FFT_RADIX 3           // points per butterfly

// sqrt(3)/2 scaled by 2^15
`define FFT_SQRT3_HALF 28378

`endif

/* rtl/fft_sample_pkg.sv */
`include "fft_defines.svh"

package fft_sample_pkg;

    // ------------------------------------------------------------
    // complex sample as carried between blocks
    // ------------------------------------------------------------
    typedef struct packed {
        logic signed [`FFT_DATA_W-1:0] re;  // real part
        logic signed [`FFT_DATA_W-1:0] im;  // imag part
    } sample_t;

    // full product of one data part and one coefficient
    typedef logic signed [`FFT_DATA_W+`FFT_COEF_W-1:0] prod_t;

endpackage

/* rtl/radix3_butterfly.sv */
`include "fft_defines.svh"

module radix3_butterfly (
    input  fft_sample_pkg::sample_t x0,
    input  fft_sample_pkg::sample_t x1,
    input  fft_sample_pkg::sample_t x2,
    output fft_sample_pkg::sample_t y0,
    output fft_sample_pkg::sample_t y1,
    output fft_sample_pkg::sample_t y2
);

    // sin(2pi/3) in q1.15
    localparam logic signed [`FFT_COEF_W-1:0] C_SIN =
        `FFT_COEF_W'(`FFT_SQRT3_HALF);

    fft_sample_pkg::sample_t s;     // x1 + x2
    fft_sample_pkg::sample_t d;     // x1 - x2
    fft_sample_pkg::sample_t m;     // x0 - s/2
    fft_sample_pkg::sample_t r;     // -j * d
    fft_sample_pkg::sample_t t;     // r scaled by sqrt3/2
    fft_sample_pkg::prod_t   p_re;
    fft_sample_pkg::prod_t   p_im;

    // ------------------------------------------------------------
    // 3-point dft, wraps at data width
    // ------------------------------------------------------------
    always_comb begin
        s.re = x1.re + x2.re;
        s.im = x1.im + x2.im;
        d.re = x1.re - x2.re;
        d.im = x1.im - x2.im;

        m.re = x0.re - (s.re >>> 1);  // cos(2pi/3) = -1/2 term
        m.im = x0.im - (s.im >>> 1);

        r.re = d.im;                  // rotate by -j
        r.im = -d.re;

        p_re = fft_sample_pkg::prod_t'(r.re) * fft_sample_pkg::prod_t'(C_SIN);
        p_im = fft_sample_pkg::prod_t'(r.im) * fft_sample_pkg::prod_t'(C_SIN);
        t.re = `FFT_DATA_W'(p_re >>> (`FFT_COEF_W - 1));  // truncate
        t.im = `FFT_DATA_W'(p_im >>> (`FFT_COEF_W - 1));

        y0.re = x0.re + s.re;         // dc bin
        y0.im = x0.im + s.im;
        y1.re = m.re + t.re;          // bin 1
        y1.im = m.im + t.im;
        y2.re = m.re - t.re;          // bin 2, mirror of bin 1
        y2.im = m.im - t.im;
    end

endmodule

/* rtl/sdf_stage.sv */
`include "fft_defines.svh"

module sdf_stage #(
    parameter int SPAN = 1  // samples per third of a group
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  fft_sample_pkg::sample_t in_data,
    output logic                    out_valid,
    output fft_sample_pkg::sample_t out_data
);

    localparam fft_ctrl_pkg::frame_pos_t GRP_LAST =
        fft_ctrl_pkg::frame_pos_t'(`FFT_RADIX * SPAN - 1);  // last slot of a group
    localparam fft_ctrl_pkg::frame_pos_t RUN_LAST =
        fft_ctrl_pkg::frame_pos_t'(`FFT_POINTS - 1);        // last output of a frame

    fft_ctrl_pkg::frame_pos_t in_cnt;     // input slot in group
    fft_ctrl_pkg::frame_pos_t out_cnt;    // output slot in group
    fft_ctrl_pkg::frame_pos_t run_cnt;    // output index in frame
    logic                     run;        // output window open
    fft_ctrl_pkg::digit_t     in_third;
    fft_ctrl_pkg::digit_t     out_third;
    logic                     bf_en;      // last third arriving
    logic                     sel_first;  // first butterfly cycle of a frame

    fft_sample_pkg::sample_t long_in, long_out;    // 2*SPAN line
    fft_sample_pkg::sample_t short_in, short_out;  // SPAN line
    fft_sample_pkg::sample_t y0, y1, y2;
    fft_sample_pkg::sample_t sel_data;

    // which third of a group a slot falls in
    function automatic fft_ctrl_pkg::digit_t third_of(input fft_ctrl_pkg::frame_pos_t cnt);
        if (cnt < SPAN) begin
            return 2'd0;
        end else if (cnt < 2 * SPAN) begin
            return 2'd1;
        end
        return 2'd2;
    endfunction

    assign in_third  = third_of(in_cnt);
    assign out_third = third_of(out_cnt);
    assign bf_en     = in_valid && (in_third == 2'd2);
    assign sel_first = bf_en && !run;  // opens the 9-cycle window

    // ------------------------------------------------------------
    // stage controller
    // ------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_cnt    <= '0;
            out_cnt   <= '0;
            run_cnt   <= '0;
            run       <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            in_cnt <= in_valid ? ((in_cnt == GRP_LAST) ? '0 : in_cnt + 1'b1) : '0;
            if (sel_first) begin
                run     <= 1'b1;
                run_cnt <= fft_ctrl_pkg::frame_pos_t'(1);  // slot 0 is this cycle
                out_cnt <= fft_ctrl_pkg::frame_pos_t'(1);
            end else if (run) begin
                run     <= (run_cnt != RUN_LAST);          // close after 9 outputs
                run_cnt <= (run_cnt == RUN_LAST) ? '0 : run_cnt + 1'b1;
                out_cnt <= (out_cnt == GRP_LAST) ? '0 : out_cnt + 1'b1;
            end
            out_valid <= sel_first || run;
        end
    end

    // ------------------------------------------------------------
    // feedback muxing
    // ------------------------------------------------------------
    always_comb begin
        long_in  = '0;
        short_in = '0;
        if (bf_en) begin
            long_in  = y2;  // bin 2 waits longest
            short_in = y1;
        end else if (in_valid) begin
            if (in_third == 2'd0) long_in = in_data;   // first third
            if (in_third == 2'd1) short_in = in_data;  // second third
        end
    end

    delay_line #(.DEPTH(2 * SPAN)) long_line_inst (
        .clk      (clk),
        .in_data  (long_in),
        .out_data (long_out)
    );

    delay_line #(.DEPTH(SPAN)) short_line_inst (
        .clk      (clk),
        .in_data  (short_in),
        .out_data (short_out)
    );

    radix3_butterfly bf_inst (
        .x0 (long_out),   // oldest third
        .x1 (short_out),
        .x2 (in_data),    // live third
        .y0 (y0),
        .y1 (y1),
        .y2 (y2)
    );

    // y0 now, then drain short line, then long line
    always_comb begin
        if (bf_en) begin
            sel_data = y0;
        end else if (out_third == 2'd1) begin
            sel_data = short_out;
        end else begin
            sel_data = long_out;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= sel_data;  // output register
    end

endmodule

/* rtl/twiddle_rotator.sv */
`include "fft_defines.svh"

module twiddle_rotator (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  fft_sample_pkg::sample_t in_data,
    output logic                    out_valid,
    output fft_sample_pkg::sample_t out_data
);

    localparam fft_ctrl_pkg::frame_pos_t POS_LAST =
        fft_ctrl_pkg::frame_pos_t'(`FFT_POINTS - 1);

    fft_ctrl_pkg::frame_pos_t       pos;    // sample index in frame
    fft_ctrl_pkg::digit_t           n_dig;  // group digit
    fft_ctrl_pkg::digit_t           k_dig;  // bin digit from stage 1
    logic [2:0]                     expo;   // n*k, 0 .. 4
    logic signed [`FFT_COEF_W-1:0]  w_re;
    logic signed [`FFT_COEF_W-1:0]  w_im;
    fft_sample_pkg::prod_t          p_re;
    fft_sample_pkg::prod_t          p_im;
    fft_sample_pkg::sample_t        rot;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos       <= '0;
            out_valid <= 1'b0;
        end else begin
            pos       <= in_valid ? ((pos == POS_LAST) ? '0 : pos + 1'b1) : '0;
            out_valid <= in_valid;  // one cycle through
        end
    end

    // ------------------------------------------------------------
    // twiddle address
    // ------------------------------------------------------------
    always_comb begin
        if (pos < `FFT_RADIX) begin
            k_dig = 2'd0;
        end else if (pos < 2 * `FFT_RADIX) begin
            k_dig = 2'd1;
        end else begin
            k_dig = 2'd2;
        end
        n_dig = fft_ctrl_pkg::digit_t'(pos - fft_ctrl_pkg::frame_pos_t'(`FFT_RADIX * k_dig));
        expo  = 3'(n_dig) * 3'(k_dig);
    end

    // w9^e = cos(2pi e/9) - j sin(2pi e/9), q1.15
    always_comb begin
        case (expo)
            3'd1:    begin w_re =  16'sd25102; w_im = -16'sd21063; end
            3'd2:    begin w_re =  16'sd5690;  w_im = -16'sd32270; end
            3'd3:    begin w_re = -16'sd16384; w_im = -16'sd28378; end
            3'd4:    begin w_re = -16'sd30792; w_im = -16'sd11207; end
            default: begin w_re = '0;          w_im = '0;          end  // bypassed
        endcase
    end

    // ------------------------------------------------------------
    // complex multiply
    // ------------------------------------------------------------
    always_comb begin
        p_re = fft_sample_pkg::prod_t'(in_data.re) * fft_sample_pkg::prod_t'(w_re)
             - fft_sample_pkg::prod_t'(in_data.im) * fft_sample_pkg::prod_t'(w_im);
        p_im = fft_sample_pkg::prod_t'(in_data.re) * fft_sample_pkg::prod_t'(w_im)
             + fft_sample_pkg::prod_t'(in_data.im) * fft_sample_pkg::prod_t'(w_re);
        rot.re = `FFT_DATA_W'(p_re >>> (`FFT_COEF_W - 1));  // drop q15 fraction
        rot.im = `FFT_DATA_W'(p_im >>> (`FFT_COEF_W - 1));
    end

    always_ff @(posedge clk) begin
        out_data <= (expo == 3'd0) ? in_data : rot;  // unit twiddle is exact
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f build.f --top-module fft9_tb
./obj_dir/Vfft9_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tests/fft9_tb.sv */
`include "fft_defines.svh"

module fft9_tb;

    localparam logic [1:0] KIND_ZERO    = 2'd0;
    localparam logic [1:0] KIND_IMPULSE = 2'd1;
    localparam logic [1:0] KIND_DC      = 2'd2;
    localparam int         RISE_LAT     = 11;  // first di_en to first do_en
    localparam int         WAIT_MAX     = 64;  // cycles before a wait gives up

    typedef struct packed {
        logic [1:0]                    kind;
        logic                          rnd;     // amplitude drawn from lfsr
        logic                          gap;     // idle frame before this one
        logic signed [`FFT_DATA_W-1:0] amp_re;
        logic signed [`FFT_DATA_W-1:0] amp_im;
    } row_t;

    logic                    clk;
    logic                    rst;
    logic                    di_en;
    fft_sample_pkg::sample_t di;
    logic                    do_en;
    fft_sample_pkg::sample_t do_data;

    row_t                    rows [$];
    int                      start_q [$];  // cycle of first di_en per frame
    fft_sample_pkg::sample_t exp_q [$];    // bins in output order
    logic [31:0]             lfsr;
    int                      cycle = 0;

    fft9_top fft9_top_inst (
        .clk     (clk),
        .rst     (rst),
        .di_en   (di_en),
        .di      (di),
        .do_en   (do_en),
        .do_data (do_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;  // read on falling edges only
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);  // galois form
    endfunction

    // magnitude up to 3640 so that 9*c still fits
    task automatic random_amp(output logic signed [`FFT_DATA_W-1:0] amp);
        logic [15:0] mag;
        logic        neg;
        mag = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr = lfsr_step(lfsr);
            mag  = {mag[14:0], lfsr[0]};  // one step per bit
        end
        lfsr = lfsr_step(lfsr);
        neg  = lfsr[0];
        mag  = mag % 16'd3641;
        amp  = neg ? -$signed(mag) : $signed(mag);
    endtask

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, want);
            stop_run();
        end
    endtask

    task automatic add_row(input logic [1:0] kind, input logic rnd, input logic gap,
                           input int re, input int im);
        row_t r;
        r.kind   = kind;
        r.rnd    = rnd;
        r.gap    = gap;
        r.amp_re = `FFT_DATA_W'(re);
        r.amp_im = `FFT_DATA_W'(im);
        rows.push_back(r);
    endtask

    // ------------------------------------------------------------
    // stimulus table of kind, random flag, gap flag, re and im
    // ------------------------------------------------------------
    task automatic load_rows();
        add_row(KIND_ZERO,    1'b0, 1'b0, 0, 0);
        add_row(KIND_IMPULSE, 1'b0, 1'b0, 1000, -2000);
        add_row(KIND_IMPULSE, 1'b0, 1'b1, 32767, -32768);  // full scale
        add_row(KIND_DC,      1'b0, 1'b0, 3640, -3640);    // largest safe dc
        add_row(KIND_DC,      1'b0, 1'b0, -1, 1);          // halving of odd sums
        add_row(KIND_ZERO,    1'b0, 1'b1, 0, 0);
        add_row(KIND_IMPULSE, 1'b1, 1'b0, 0, 0);
        add_row(KIND_DC,      1'b1, 1'b1, 0, 0);
        add_row(KIND_DC,      1'b1, 1'b0, 0, 0);
        add_row(KIND_IMPULSE, 1'b1, 1'b1, 0, 0);
        add_row(KIND_DC,      1'b0, 1'b0, 7, 0);
        add_row(KIND_ZERO,    1'b0, 1'b0, 0, 0);
    endtask

    function automatic fft_sample_pkg::sample_t input_sample(input row_t r, input int idx);
        fft_sample_pkg::sample_t x;
        x = '0;
        if (r.kind == KIND_DC || (r.kind == KIND_IMPULSE && idx == 0)) begin
            x.re = r.amp_re;
            x.im = r.amp_im;
        end
        return x;
    endfunction

    // bin 0 first then digit-reversed order
    function automatic fft_sample_pkg::sample_t expected_bin(input row_t r, input int idx);
        fft_sample_pkg::sample_t e;
        e = '0;
        if (r.kind == KIND_IMPULSE) begin
            e.re = r.amp_re;  // flat spectrum
            e.im = r.amp_im;
        end else if (r.kind == KIND_DC && idx == 0) begin
            e.re = `FFT_DATA_W'(`FFT_POINTS * r.amp_re);  // all energy in bin 0
            e.im = `FFT_DATA_W'(`FFT_POINTS * r.amp_im);
        end
        return e;
    endfunction

    // ------------------------------------------------------------
    // driver and monitor
    // ------------------------------------------------------------
    task automatic drive_frames();
        row_t r;
        for (int f = 0; f < rows.size(); f++) begin
            r = rows[f];
            if (r.gap) begin
                repeat (`FFT_POINTS) begin
                    @(negedge clk);
                    di_en = 1'b0;
                    di    = '0;
                end
            end
            if (r.rnd) begin
                random_amp(r.amp_re);
                random_amp(r.amp_im);
            end
            for (int i = 0; i < `FFT_POINTS; i++) begin
                exp_q.push_back(expected_bin(r, i));
            end
            for (int i = 0; i < `FFT_POINTS; i++) begin
                @(negedge clk);
                if (i == 0) begin
                    start_q.push_back(cycle);
                end
                di_en = 1'b1;
                di    = input_sample(r, i);
            end
        end
        @(negedge clk);
        di_en = 1'b0;
        di    = '0;
    endtask

    task automatic check_frames(input int count);
        int                      waited;
        int                      start;
        fft_sample_pkg::sample_t want;
        for (int f = 0; f < count; f++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                if (waited > WAIT_MAX) begin
                    $display("timeout while waiting for do_en of frame %0d", f);
                    stop_run();
                end
            end while (!do_en);
            if (start_q.size() == 0) begin
                $display("do_en went high with no frame in flight");
                stop_run();
            end
            start = start_q.pop_front();
            compare("do_en rise cycle", cycle, start + RISE_LAT);
            for (int i = 0; i < `FFT_POINTS; i++) begin
                if (i > 0) begin
                    @(negedge clk);
                    compare("do_en", do_en, 32'd1);  // window has no holes
                end
                want = exp_q.pop_front();
                compare("do_data.re", do_data.re, want.re);
                compare("do_data.im", do_data.im, want.im);
            end
        end
        @(negedge clk);
        compare("do_en", do_en, 32'd0);  // closes after the last frame
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        rst    = 1'b1;
        di_en  = 1'b0;
        di     = '0;
        lfsr   = 32'h6448_86e9;
        load_rows();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2 * `FFT_POINTS) begin
            @(negedge clk);
            compare("do_en", do_en, 32'd0);  // quiet before any input
        end
        fork
            drive_frames();
            check_frames(rows.size());
        join
        $display("Everything OK");
        $finish;
    end

endmodule
